// File: hdl/engine_regs_pkg.sv
/*
 * Register map of the read traffic engine
 * Write and read indices, control-word layout and counter widths
 */
`default_nettype none

package engine_regs_pkg;

    // Register port geometry
    localparam int CSR_IDX_W = 4;
    localparam int CSR_W = 64;

    // ======================================================================
    // Write indices
    // ======================================================================
    localparam logic [CSR_IDX_W-1:0] WR_IDX_BASE = 4'd0;
    localparam logic [CSR_IDX_W-1:0] WR_IDX_CTRL = 4'd1;
    localparam logic [CSR_IDX_W-1:0] WR_IDX_MASK = 4'd2;
    localparam logic [CSR_IDX_W-1:0] WR_IDX_READY = 4'd3;

    // ======================================================================
    // Read indices, anything else reads zero
    // ======================================================================
    localparam logic [CSR_IDX_W-1:0] RD_IDX_STATE = 4'd0;
    localparam logic [CSR_IDX_W-1:0] RD_IDX_BURSTS_REQ = 4'd1;
    localparam logic [CSR_IDX_W-1:0] RD_IDX_LINES_RESP = 4'd2;
    localparam logic [CSR_IDX_W-1:0] RD_IDX_BURSTS_RESP = 4'd3;
    localparam logic [CSR_IDX_W-1:0] RD_IDX_SUM = 4'd4;
    localparam logic [CSR_IDX_W-1:0] RD_IDX_MAX_ACTIVE = 4'd5;

    // Statistic and bookkeeping widths
    localparam int COUNTER_W = 48;
    localparam int LINE_CNT_W = 12;
    localparam int OFFSET_W = 32;
    localparam int CTRL_FIELD_W = 16;

    // Read control word, high field first
    typedef struct packed {
        logic [CTRL_FIELD_W-1:0] max_active;
        logic [CTRL_FIELD_W-1:0] num_bursts;
        logic [CTRL_FIELD_W-1:0] start_offset;
        logic [CTRL_FIELD_W-1:0] burst_len;
    } t_rd_ctrl;

    // One register word, seen raw or as the control layout
    typedef union packed {
        logic [CSR_W-1:0] raw;
        t_rd_ctrl ctrl;
    } csr_word_u;

endpackage

`default_nettype wire

// File: hdl/mem_bus_pkg.sv
/*
 * Read bus geometry
 * Data and address widths, AXI len and id sizes, checksum width
 */
`default_nettype none

package mem_bus_pkg;

    // One beat is one full line
    localparam int DATA_W = 512;

    // Line address plus byte index gives the byte address
    localparam int LINE_ADDR_W = 42;
    localparam int BYTE_IDX_W = 6;
    localparam int ADDR_W = LINE_ADDR_W + BYTE_IDX_W;

    // AXI len field and transaction id
    localparam int BURST_LEN_W = 8;
    localparam int ID_W = 4;

    // Non-zero first id so ids do not track the address
    localparam logic [ID_W-1:0] RD_ID_START = ID_W'(37);

    // Response checksum
    localparam int SUM_W = 32;

endpackage

`default_nettype wire

// File: hdl/engine_ifs.sv
/*
 * Internal interfaces of the read engine
 * Held read configuration and collected read statistics
 */
`timescale 1ns/1ps
`default_nettype none

interface rd_cfg_if;
    import engine_regs_pkg::*;
    import mem_bus_pkg::*;

    // Levels held by the register block
    logic [LINE_ADDR_W-1:0] base_addr;
    logic [OFFSET_W-1:0] start_offset;
    logic [OFFSET_W-1:0] offset_mask;
    // Lines per burst, one bit wider than AXI len
    logic [BURST_LEN_W:0] burst_len;
    logic [CTRL_FIELD_W-1:0] burst_count;
    // Raw max-active field, 0 means no limit
    logic [LINE_CNT_W-1:0] max_active;
    logic [31:0] ready_mask;

    modport src (output base_addr, start_offset, offset_mask, burst_len,
                 burst_count, max_active, ready_mask);
    modport dst (input base_addr, start_offset, offset_mask, burst_len,
                 burst_count, max_active, ready_mask);
endinterface

interface rd_stat_if;
    import engine_regs_pkg::*;
    import mem_bus_pkg::*;

    // ======================================================================
    // Request side
    // ======================================================================
    logic [COUNTER_W-1:0] bursts_req;
    logic [LINE_CNT_W-1:0] max_active;
    logic req_done;

    // ======================================================================
    // Response side
    // ======================================================================
    logic [COUNTER_W-1:0] beats_resp;
    logic [COUNTER_W-1:0] bursts_resp;
    logic [SUM_W-1:0] sum;
    logic id_error;
    // One cycle per accepted beat, retires an in-flight line
    logic beat_pulse;

    modport src (output bursts_req, max_active, req_done, beats_resp,
                 bursts_resp, sum, id_error, beat_pulse);
    modport dst (input bursts_req, max_active, req_done, beats_resp,
                 bursts_resp, sum, id_error, beat_pulse);
endinterface

`default_nettype wire

// File: hdl/engine_csr_regs.sv
/*
 * Register write decode
 * Holds the read configuration written through the register port
 */
`timescale 1ns/1ps
`default_nettype none

module engine_csr_regs (
    input  logic clk,
    input  logic state_reset,
    input  logic csr_wr_req,
    input  logic [engine_regs_pkg::CSR_IDX_W-1:0] csr_wr_idx,
    input  logic [engine_regs_pkg::CSR_W-1:0] csr_wr_data,
    rd_cfg_if.src cfg
);
    import engine_regs_pkg::*;
    import mem_bus_pkg::*;

    // Incoming word, decoded by register
    csr_word_u wr_word;

    assign wr_word.raw = csr_wr_data;

    // ======================================================================
    // Register writes, visible the cycle after the strobe
    // ======================================================================
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            cfg.base_addr <= '0;
            cfg.start_offset <= '0;
            cfg.offset_mask <= '0;
            cfg.burst_len <= '0;
            cfg.burst_count <= '0;
            cfg.max_active <= '0;
            // R channel always ready by default
            cfg.ready_mask <= '1;
        end
        else if (csr_wr_req)
        begin
            case (csr_wr_idx)
                WR_IDX_BASE:
                begin
                    cfg.base_addr <= wr_word.raw[LINE_ADDR_W-1:0];
                end
                WR_IDX_CTRL:
                begin
                    // Only the low bits of each control field are kept
                    cfg.max_active <= wr_word.ctrl.max_active[LINE_CNT_W-1:0];
                    cfg.burst_count <= wr_word.ctrl.num_bursts;
                    cfg.start_offset <= OFFSET_W'(wr_word.ctrl.start_offset);
                    cfg.burst_len <= wr_word.ctrl.burst_len[BURST_LEN_W:0];
                end
                WR_IDX_MASK:
                begin
                    cfg.offset_mask <= wr_word.raw[OFFSET_W-1:0];
                end
                WR_IDX_READY:
                begin
                    cfg.ready_mask <= wr_word.raw[31:0];
                end
                default:
                begin
                    // Unmapped index, nothing stored
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/rd_req_gen.sv
/*
 * Read request generator
 * Issues AR bursts over a masked offset range under a lines-in-flight cap
 */
`timescale 1ns/1ps
`default_nettype none

module rd_req_gen (
    input  logic clk,
    input  logic state_reset,
    input  logic run,
    input  logic ar_ready,
    output logic ar_valid,
    output logic [mem_bus_pkg::ADDR_W-1:0] ar_addr,
    output logic [mem_bus_pkg::BURST_LEN_W-1:0] ar_len,
    output logic [mem_bus_pkg::ID_W-1:0] ar_id,
    rd_cfg_if.dst cfg,
    rd_stat_if.src stat
);
    import engine_regs_pkg::*;
    import mem_bus_pkg::*;

    logic [OFFSET_W-1:0] cur_offset;
    logic [CTRL_FIELD_W-1:0] bursts_left;
    logic unlimited;
    logic done;
    logic [ID_W-1:0] next_id;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic ar_accept;

    // In-flight tracking
    logic [LINE_CNT_W-1:0] cur_active;
    logic [LINE_CNT_W-1:0] new_lines;
    logic [LINE_CNT_W-1:0] active_next;
    logic [LINE_CNT_W-1:0] cap;
    logic quota_exceeded;

    // ======================================================================
    // AR channel
    // ======================================================================
    assign ar_valid = run && !done && !quota_exceeded;
    assign ar_accept = ar_valid && ar_ready;

    // Base plus offset, then byte index zero
    assign line_addr = cfg.base_addr + LINE_ADDR_W'(cur_offset);
    assign ar_addr = {line_addr, BYTE_IDX_W'(0)};
    assign ar_len = BURST_LEN_W'(cfg.burst_len - 1'b1);
    assign ar_id = next_id;

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            done <= 1'b0;
            unlimited <= 1'b0;
            bursts_left <= '0;
            cur_offset <= '0;
            next_id <= RD_ID_START;
        end
        else if (!run)
        begin
            // Idle, so preload the next run
            cur_offset <= cfg.start_offset;
            bursts_left <= cfg.burst_count;
            unlimited <= (cfg.burst_count == '0);
            next_id <= RD_ID_START;
            // Zero base keeps the engine parked
            done <= (cfg.base_addr == '0);
        end
        else if (ar_accept)
        begin
            cur_offset <= (cur_offset + OFFSET_W'(cfg.burst_len)) & cfg.offset_mask;
            bursts_left <= bursts_left - 1'b1;
            next_id <= next_id + 1'b1;
            done <= !unlimited && (bursts_left == CTRL_FIELD_W'(1));
        end
    end

    assign stat.req_done = done;

    // ======================================================================
    // Lines in flight and the cap
    // ======================================================================

    // Field of 0 wraps to all ones, no practical limit
    assign cap = cfg.max_active - LINE_CNT_W'(1);
    assign new_lines = ar_accept ? LINE_CNT_W'(cfg.burst_len) : '0;
    assign active_next = cur_active + new_lines - LINE_CNT_W'(stat.beat_pulse);

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            cur_active <= '0;
            quota_exceeded <= 1'b0;
            stat.max_active <= '0;
            stat.bursts_req <= '0;
        end
        else
        begin
            cur_active <= active_next;
            // Room for one more full burst?
            quota_exceeded <= ({1'b0, active_next} + (LINE_CNT_W + 1)'(cfg.burst_len))
                              > {1'b0, cap};
            if (cur_active > stat.max_active)
            begin
                stat.max_active <= cur_active;
            end
            if (ar_accept)
            begin
                stat.bursts_req <= stat.bursts_req + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rd_rsp_check.sv
/*
 * Read response checker
 * Rotating R ready, beat and burst counts, data checksum and id check
 */
`timescale 1ns/1ps
`default_nettype none

module rd_rsp_check (
    input  logic clk,
    input  logic state_reset,
    input  logic run,
    input  logic r_valid,
    input  logic [mem_bus_pkg::DATA_W-1:0] r_data,
    input  logic [mem_bus_pkg::ID_W-1:0] r_id,
    input  logic r_last,
    output logic r_ready,
    rd_cfg_if.dst cfg,
    rd_stat_if.src stat
);
    import mem_bus_pkg::*;

    logic [31:0] ready_rot;
    logic r_accept;
    logic [SUM_W-1:0] sum_term;
    logic [ID_W-1:0] exp_id;

    // ======================================================================
    // Ready throttle
    // ======================================================================

    // Bit 0 is this cycle's ready
    assign r_ready = ready_rot[0];
    assign r_accept = r_valid && r_ready;

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            ready_rot <= '1;
        end
        else if (!run)
        begin
            ready_rot <= cfg.ready_mask;
        end
        else
        begin
            ready_rot <= {ready_rot[30:0], ready_rot[31]};
        end
    end

    // ======================================================================
    // Counters and checksum
    // ======================================================================

    // High 16 bits of the line over its low 16 bits
    assign sum_term = {r_data[DATA_W-1 -: 16], r_data[15:0]};

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            stat.beat_pulse <= 1'b0;
            stat.beats_resp <= '0;
            stat.bursts_resp <= '0;
            stat.sum <= '0;
        end
        else
        begin
            stat.beat_pulse <= r_accept;
            if (r_accept)
            begin
                stat.beats_resp <= stat.beats_resp + 1'b1;
                stat.sum <= stat.sum + sum_term;
            end
            if (r_accept && r_last)
            begin
                stat.bursts_resp <= stat.bursts_resp + 1'b1;
            end
        end
    end

    // ======================================================================
    // In-order id check, one id per burst
    // ======================================================================
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            exp_id <= RD_ID_START;
            stat.id_error <= 1'b0;
        end
        else
        begin
            if (!run)
            begin
                exp_id <= RD_ID_START;
            end
            else if (r_accept && r_last)
            begin
                exp_id <= exp_id + 1'b1;
            end
            // Sticky until the next state reset
            if (r_accept && (r_id != exp_id))
            begin
                stat.id_error <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/engine_status.sv
/*
 * Status readback
 * Registered read mux over the statistics and the engine-active flag
 */
`timescale 1ns/1ps
`default_nettype none

module engine_status (
    input  logic clk,
    input  logic state_reset,
    input  logic run,
    input  logic [engine_regs_pkg::CSR_IDX_W-1:0] csr_rd_idx,
    output logic [engine_regs_pkg::CSR_W-1:0] csr_rd_data,
    output logic active,
    rd_stat_if.dst stat
);
    import engine_regs_pkg::*;

    // Busy while issuing, or while bursts are still owed
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            active <= 1'b0;
        end
        else
        begin
            active <= (run && !stat.req_done) || (stat.bursts_req != stat.bursts_resp);
        end
    end

    // ======================================================================
    // Read mux, one cycle from index to data
    // ======================================================================
    always_ff @(posedge clk)
    begin
        case (csr_rd_idx)
            RD_IDX_STATE:
                csr_rd_data <= {{(CSR_W - 3){1'b0}}, stat.id_error, active, run};
            RD_IDX_BURSTS_REQ:
                csr_rd_data <= CSR_W'(stat.bursts_req);
            RD_IDX_LINES_RESP:
                csr_rd_data <= CSR_W'(stat.beats_resp);
            RD_IDX_BURSTS_RESP:
                csr_rd_data <= CSR_W'(stat.bursts_resp);
            RD_IDX_SUM:
                csr_rd_data <= CSR_W'(stat.sum);
            RD_IDX_MAX_ACTIVE:
                csr_rd_data <= CSR_W'(stat.max_active);
            default:
                csr_rd_data <= '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mem_rd_engine.sv
/*
 * Host memory read traffic engine, top level
 * Register decode, AR generator, R checker and status readback
 */
`timescale 1ns/1ps
`default_nettype none

module mem_rd_engine (
    input  logic clk,
    input  logic state_reset,

    // Register port
    input  logic csr_wr_req,
    input  logic [engine_regs_pkg::CSR_IDX_W-1:0] csr_wr_idx,
    input  logic [engine_regs_pkg::CSR_W-1:0] csr_wr_data,
    input  logic [engine_regs_pkg::CSR_IDX_W-1:0] csr_rd_idx,
    output logic [engine_regs_pkg::CSR_W-1:0] csr_rd_data,

    // Run control
    input  logic run,
    output logic active,

    // AR channel
    output logic ar_valid,
    input  logic ar_ready,
    output logic [mem_bus_pkg::ADDR_W-1:0] ar_addr,
    output logic [mem_bus_pkg::BURST_LEN_W-1:0] ar_len,
    output logic [mem_bus_pkg::ID_W-1:0] ar_id,

    // R channel
    input  logic r_valid,
    output logic r_ready,
    input  logic [mem_bus_pkg::DATA_W-1:0] r_data,
    input  logic [mem_bus_pkg::ID_W-1:0] r_id,
    input  logic r_last
);

    rd_cfg_if cfg_if ();
    rd_stat_if stat_if ();

    // ======================================================================
    // Input side
    // ======================================================================
    engine_csr_regs u_csr_regs (
        .clk         (clk),
        .state_reset (state_reset),
        .csr_wr_req  (csr_wr_req),
        .csr_wr_idx  (csr_wr_idx),
        .csr_wr_data (csr_wr_data),
        .cfg         (cfg_if.src)
    );

    // ======================================================================
    // Traffic generation and checking
    // ======================================================================
    rd_req_gen u_req_gen (
        .clk         (clk),
        .state_reset (state_reset),
        .run         (run),
        .ar_ready    (ar_ready),
        .ar_valid    (ar_valid),
        .ar_addr     (ar_addr),
        .ar_len      (ar_len),
        .ar_id       (ar_id),
        .cfg         (cfg_if.dst),
        .stat        (stat_if.src)
    );

    rd_rsp_check u_rsp_check (
        .clk         (clk),
        .state_reset (state_reset),
        .run         (run),
        .r_valid     (r_valid),
        .r_data      (r_data),
        .r_id        (r_id),
        .r_last      (r_last),
        .r_ready     (r_ready),
        .cfg         (cfg_if.dst),
        .stat        (stat_if.src)
    );

    // Output side
    engine_status u_status (
        .clk         (clk),
        .state_reset (state_reset),
        .run         (run),
        .csr_rd_idx  (csr_rd_idx),
        .csr_rd_data (csr_rd_data),
        .active      (active),
        .stat        (stat_if.dst)
    );

endmodule

`default_nettype wire

// File: sim/tb_mem_responder.sv
/*
 * Behavioral read memory for the engine testbench
 * Queues AR requests and answers each in order with patterned R beats
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_responder (
    input  logic clk,
    input  logic state_reset,
    input  logic gaps,
    input  logic corrupt_id,
    input  logic ar_valid,
    input  logic ar_ready,
    input  logic [mem_bus_pkg::ADDR_W-1:0] ar_addr,
    input  logic [mem_bus_pkg::BURST_LEN_W-1:0] ar_len,
    input  logic [mem_bus_pkg::ID_W-1:0] ar_id,
    output logic r_valid,
    input  logic r_ready,
    output logic [mem_bus_pkg::DATA_W-1:0] r_data,
    output logic [mem_bus_pkg::ID_W-1:0] r_id,
    output logic r_last
);
    import mem_bus_pkg::*;

    // Outstanding requests, oldest at index 0
    logic [LINE_ADDR_W-1:0] line_q[$];
    logic [BURST_LEN_W-1:0] len_q[$];
    logic [ID_W-1:0] id_q[$];
    int beat;
    logic r_taken;
    logic [63:0] line_word;

    initial
    begin
        r_valid = 1'b0;
        r_data = '0;
        r_id = '0;
        r_last = 1'b0;
        beat = 0;
        r_taken = 1'b0;
    end

    // Handshakes seen at the rising edge
    always @(posedge clk)
    begin
        if (state_reset)
        begin
            line_q.delete();
            len_q.delete();
            id_q.delete();
            beat = 0;
            r_taken = 1'b0;
        end
        else
        begin
            r_taken = r_valid && r_ready;
            if (r_taken)
            begin
                if (beat == int'(len_q[0]))
                begin
                    // Last beat of the burst retires the request
                    void'(line_q.pop_front());
                    void'(len_q.pop_front());
                    void'(id_q.pop_front());
                    beat = 0;
                end
                else
                begin
                    beat = beat + 1;
                end
            end
            if (ar_valid && ar_ready)
            begin
                line_q.push_back(ar_addr[ADDR_W-1:BYTE_IDX_W]);
                len_q.push_back(ar_len);
                id_q.push_back(ar_id);
            end
        end
    end

    // ======================================================================
    // R beats, driven on the falling edge
    // ======================================================================
    always @(negedge clk)
    begin
        if (state_reset || line_q.size() == 0)
        begin
            r_valid <= 1'b0;
        end
        else
        begin
            // A pending beat stays valid, otherwise an optional random gap
            if (!(r_valid && !r_taken))
            begin
                r_valid <= !gaps || ($urandom_range(3) != 0);
            end
            // Line address low, its inverse at the top
            line_word = 64'(line_q[0] + LINE_ADDR_W'(beat));
            r_data <= {~line_word, {(DATA_W - 128){1'b0}}, line_word};
            r_id <= corrupt_id ? (id_q[0] ^ ID_W'(1)) : id_q[0];
            r_last <= (beat == int'(len_q[0]));
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_mem_rd_engine.sv
/*
 * Testbench of the read traffic engine
 * Drives the register port and run, checks counters, checksum and id error
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_rd_engine;
    import engine_regs_pkg::*;
    import mem_bus_pkg::*;

    localparam int CLK_HALF = 10;
    localparam int WAIT_LIMIT = 20000;
    // Two ready cycles in every 32
    localparam logic [31:0] SPARSE_READY = 32'h0100_0001;

    logic clk;
    logic state_reset;
    logic csr_wr_req;
    logic [CSR_IDX_W-1:0] csr_wr_idx;
    logic [CSR_W-1:0] csr_wr_data;
    logic [CSR_IDX_W-1:0] csr_rd_idx;
    logic [CSR_W-1:0] csr_rd_data;
    logic run;
    logic active;
    logic ar_valid;
    logic ar_ready;
    logic [ADDR_W-1:0] ar_addr;
    logic [BURST_LEN_W-1:0] ar_len;
    logic [ID_W-1:0] ar_id;
    logic r_valid;
    logic r_ready;
    logic [DATA_W-1:0] r_data;
    logic [ID_W-1:0] r_id;
    logic r_last;

    // Stimulus knobs
    logic ar_stalls;
    logic r_gaps;
    logic corrupt_id;

    int error_count;
    int check_count;
    int test_count;
    int errors_before;

    // R ready seen over the first mask period of a run
    int run_cycles;
    int ready_cycles;

    mem_rd_engine u_dut (
        .clk         (clk),
        .state_reset (state_reset),
        .csr_wr_req  (csr_wr_req),
        .csr_wr_idx  (csr_wr_idx),
        .csr_wr_data (csr_wr_data),
        .csr_rd_idx  (csr_rd_idx),
        .csr_rd_data (csr_rd_data),
        .run         (run),
        .active      (active),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar_addr     (ar_addr),
        .ar_len      (ar_len),
        .ar_id       (ar_id),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r_data      (r_data),
        .r_id        (r_id),
        .r_last      (r_last)
    );

    tb_mem_responder u_mem (
        .clk         (clk),
        .state_reset (state_reset),
        .gaps        (r_gaps),
        .corrupt_id  (corrupt_id),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar_addr     (ar_addr),
        .ar_len      (ar_len),
        .ar_id       (ar_id),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r_data      (r_data),
        .r_id        (r_id),
        .r_last      (r_last)
    );

    always #(CLK_HALF) clk = ~clk;

    // AR back-pressure, random when enabled
    always @(negedge clk)
    begin
        ar_ready <= ar_stalls ? ($urandom_range(2) != 0) : 1'b1;
    end

    // Any rotation of the mask shows each bit once in 32 cycles
    always @(posedge clk)
    begin
        if (state_reset)
        begin
            run_cycles <= 0;
            ready_cycles <= 0;
        end
        else if (run && run_cycles < 32)
        begin
            run_cycles <= run_cycles + 1;
            ready_cycles <= ready_cycles + (r_ready ? 1 : 0);
        end
    end

    // ======================================================================
    // Reference model of the checksum
    // ======================================================================
    function automatic logic [SUM_W-1:0] expected_sum(
        input logic [LINE_ADDR_W-1:0] base,
        input logic [OFFSET_W-1:0] start,
        input logic [OFFSET_W-1:0] mask,
        input int len,
        input int bursts
    );
        logic [OFFSET_W-1:0] off;
        logic [LINE_ADDR_W-1:0] line;
        logic [63:0] low_word;
        logic [63:0] high_word;
        logic [SUM_W-1:0] sum;
        int b;
        int k;
        off = start;
        sum = '0;
        for (b = 0; b < bursts; b++)
        begin
            for (k = 0; k < len; k++)
            begin
                line = base + LINE_ADDR_W'(off) + LINE_ADDR_W'(k);
                low_word = 64'(line);
                high_word = ~low_word;
                // Top 16 bits of the beat over its bottom 16 bits
                sum = sum + {high_word[63:48], low_word[15:0]};
            end
            // First burst starts unmasked, later ones wrap under the mask
            off = (off + OFFSET_W'(len)) & mask;
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("** Error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        state_reset <= 1'b1;
        run <= 1'b0;
        repeat (3) @(negedge clk);
        state_reset <= 1'b0;
    endtask

    task automatic write_reg(input logic [CSR_IDX_W-1:0] idx, input logic [CSR_W-1:0] data);
        @(negedge clk);
        csr_wr_req <= 1'b1;
        csr_wr_idx <= idx;
        csr_wr_data <= data;
        @(negedge clk);
        csr_wr_req <= 1'b0;
    endtask

    // Read data is registered, one cycle after the index
    task automatic read_reg(input logic [CSR_IDX_W-1:0] idx, output logic [CSR_W-1:0] value);
        @(negedge clk);
        csr_rd_idx <= idx;
        @(negedge clk);
        value = csr_rd_data;
    endtask

    task automatic configure(input logic [LINE_ADDR_W-1:0] base, input logic [31:0] start,
                             input logic [31:0] mask, input int len, input int bursts,
                             input int cap, input logic [31:0] ready);
        write_reg(WR_IDX_BASE, 64'(base));
        // Control word, max active over bursts over start over length
        write_reg(WR_IDX_CTRL, {16'(cap), 16'(bursts), 16'(start), 16'(len)});
        write_reg(WR_IDX_MASK, 64'(mask));
        write_reg(WR_IDX_READY, {32'h0, ready});
    endtask

    task automatic wait_active(input logic level);
        int cycles;
        cycles = 0;
        while (active !== level && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (active !== level)
        begin
            $display("Timeout, active did not go to %0d within %0d cycles", level, WAIT_LIMIT);
            $display("Regression failed");
            $finish;
        end
    endtask

    // Config is preloaded while run is low, so idle a little first
    task automatic run_traffic();
        repeat (2) @(negedge clk);
        run <= 1'b1;
        wait_active(1'b1);
        wait_active(1'b0);
        run <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_counts(input int len, input int bursts);
        logic [CSR_W-1:0] value;
        read_reg(RD_IDX_BURSTS_REQ, value);
        check_value("bursts_req", value, 64'(bursts));
        read_reg(RD_IDX_BURSTS_RESP, value);
        check_value("bursts_resp", value, 64'(bursts));
        read_reg(RD_IDX_LINES_RESP, value);
        check_value("lines_resp", value, 64'(len * bursts));
        // Stopped, idle and no id error
        read_reg(RD_IDX_STATE, value);
        check_value("state", value, 64'h0);
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("test %0d %s: ok", test_count, name);
        end
        else
        begin
            $display("test %0d %s: %0d mismatches", test_count, name,
                     error_count - errors_before);
        end
        errors_before = error_count;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial
    begin
        int i;
        int len;
        int bursts;
        int cap;
        int bound;
        logic [LINE_ADDR_W-1:0] base;
        logic [31:0] start;
        logic [31:0] mask;
        logic [CSR_W-1:0] value;

        clk = 1'b0;
        state_reset = 1'b1;
        csr_wr_req = 1'b0;
        csr_wr_idx = '0;
        csr_wr_data = '0;
        csr_rd_idx = '0;
        run = 1'b0;
        ar_ready = 1'b1;
        ar_stalls = 1'b0;
        r_gaps = 1'b0;
        corrupt_id = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        errors_before = 0;
        void'($urandom(32'h1d17_fe25));

        // Everything reads zero after reset
        apply_reset();
        for (i = 0; i < 8; i++)
        begin
            read_reg(CSR_IDX_W'(i), value);
            check_value("csr_rd_data", value, 64'h0);
        end
        finish_test("readback after reset");

        // Plain limited run
        apply_reset();
        configure(42'h1000, 32'd0, 32'hffff_ffff, 4, 6, 0, 32'hffff_ffff);
        run_traffic();
        check_counts(4, 6);
        read_reg(RD_IDX_SUM, value);
        check_value("sum", value, 64'(expected_sum(42'h1000, 0, 32'hffff_ffff, 4, 6)));
        finish_test("limited run counts");

        // Random parameters, stalls on both channels, wrapping mask
        apply_reset();
        base = LINE_ADDR_W'({$urandom(), $urandom()});
        if (base == '0)
        begin
            base = LINE_ADDR_W'(1);
        end
        start = 32'($urandom_range(63));
        mask = 32'h3f;
        len = 1 + $urandom_range(7);
        bursts = 16 + $urandom_range(24);
        ar_stalls <= 1'b1;
        r_gaps <= 1'b1;
        configure(base, start, mask, len, bursts, 0, 32'hffff_ffff);
        run_traffic();
        check_counts(len, bursts);
        read_reg(RD_IDX_SUM, value);
        check_value("sum", value, 64'(expected_sum(base, start, mask, len, bursts)));
        finish_test("checksum under stalls");

        // In-flight cap with a slow R channel
        apply_reset();
        len = 4;
        cap = 10;
        bursts = 30;
        ar_stalls <= 1'b0;
        configure(42'h2_0000, 32'd8, 32'hffff, len, bursts, cap, 32'hffff_ffff);
        run_traffic();
        check_counts(len, bursts);
        bound = ((cap - 1 + len - 1) / len) * len;
        read_reg(RD_IDX_MAX_ACTIVE, value);
        check_value("max_active_within_cap", 64'(value <= 64'(bound)), 64'h1);
        check_value("max_active_nonzero", 64'(value != 64'h0), 64'h1);
        finish_test("in-flight cap");

        // Sparse R ready mask
        apply_reset();
        r_gaps <= 1'b0;
        configure(42'h3_4000, 32'd0, 32'hff, 3, 5, 0, SPARSE_READY);
        run_traffic();
        check_counts(3, 5);
        check_value("r_ready_cycles", 64'(ready_cycles), 64'($countones(SPARSE_READY)));
        finish_test("sparse ready mask");

        // Bad response id sets the sticky error
        apply_reset();
        corrupt_id <= 1'b1;
        configure(42'h5000, 32'd0, 32'hff, 2, 4, 0, 32'hffff_ffff);
        run_traffic();
        corrupt_id <= 1'b0;
        read_reg(RD_IDX_STATE, value);
        check_value("state", value, 64'h4);
        apply_reset();
        read_reg(RD_IDX_STATE, value);
        check_value("state", value, 64'h0);
        finish_test("id error and clear");

        $display("tests %0d, checks %0d, mismatches %0d", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/engine_regs_pkg.sv
hdl/mem_bus_pkg.sv
hdl/engine_ifs.sv
hdl/engine_csr_regs.sv
hdl/rd_req_gen.sv
hdl/rd_rsp_check.sv
hdl/engine_status.sv
hdl/mem_rd_engine.sv
sim/tb_mem_responder.sv
sim/tb_mem_rd_engine.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_mem_rd_engine -Mdir obj_dir \
    && ./obj_dir/Vtb_mem_rd_engine > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0
